//--- Makefile
VERILATOR ?= verilator
FLAGS := --binary --timing --assert
TOP := tb_branch_predictor
FILELIST := verilog.f
BUILD := obj_dir
PASS_MSG := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the run passes only when the simulation prints the pass message
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- rtl/bht_table.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module bht_table
(
	input logic CLK,
	input logic reset,

	// three combinational read ports, one per stage
	input logic [`BP_SET_W-1:0] rd_set_a,
	input logic [`BP_SET_W-1:0] rd_set_b,
	input logic [`BP_SET_W-1:0] rd_set_c,
	output bp_pkg::bht_entry_t set_a [`BP_WAYS],
	output bp_pkg::bht_entry_t set_b [`BP_WAYS],
	output bp_pkg::bht_entry_t set_c [`BP_WAYS],

	// decode allocation
	input logic alloc_en,
	input logic [`BP_SET_W-1:0] alloc_set,
	input logic [`BP_TAG_W-1:0] alloc_tag,
	input logic [`BP_PC_W-1:0] alloc_target,
	input logic alloc_is_jump,

	// execute counter write-back
	input logic upd_en,
	input logic [`BP_SET_W-1:0] upd_set,
	input logic [`BP_WAY_W-1:0] upd_way,
	input logic [`BP_CTR_W-1:0] upd_ctr
);

	localparam int NUM_SETS = 1 << `BP_SET_W;

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	// valid bits are control state and get cleared
	logic valid_q [NUM_SETS][`BP_WAYS];
	// payload arrays
	logic [`BP_TAG_W-1:0] tag_q [NUM_SETS][`BP_WAYS];
	logic [`BP_PC_W-1:0] target_q [NUM_SETS][`BP_WAYS];
	logic [`BP_CTR_W-1:0] ctr_q [NUM_SETS][`BP_WAYS];
	// fifo replacement pointer, one per set
	logic [`BP_WAY_W-1:0] ptr_q [NUM_SETS];

	// way that the pointer names for this allocation
	logic [`BP_WAY_W-1:0] alloc_way;
	// jumps start strongly taken, branches weakly not taken
	logic [`BP_CTR_W-1:0] alloc_ctr;
	// update collides with the allocated entry
	logic upd_blocked;

	assign alloc_way = ptr_q[alloc_set];
	assign alloc_ctr = alloc_is_jump ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_WEAK_NT;
	assign upd_blocked = alloc_en && (alloc_set == upd_set) && (alloc_way == upd_way);

	//////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////

	// gather one way of one set back into an entry
	function automatic bp_pkg::bht_entry_t entry_at(input logic [`BP_SET_W-1:0] s,
			input int w);
		bp_pkg::bht_entry_t e;
		e.valid = valid_q[s][w];
		e.tag = tag_q[s][w];
		e.target = target_q[s][w];
		e.ctr = ctr_q[s][w];
		return e;
	endfunction

	always_comb
	begin
		for (int w = 0; w < `BP_WAYS; w++)
		begin
			set_a[w] = entry_at(rd_set_a, w);
			set_b[w] = entry_at(rd_set_b, w);
			set_c[w] = entry_at(rd_set_c, w);
		end
	end

	//////////////////////////////////////////////////
	// writes
	//////////////////////////////////////////////////

	// valid bits and pointers
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
			begin
				ptr_q[s] <= '0;
				for (int w = 0; w < `BP_WAYS; w++)
				begin
					valid_q[s][w] <= 1'b0;
				end
			end
		end
		else if (alloc_en)
		begin
			valid_q[alloc_set][alloc_way] <= 1'b1;
			// wraps modulo the way count
			ptr_q[alloc_set] <= alloc_way + 1'b1;
		end
	end

	// entry payload, allocation has priority over the counter update
	always_ff @(posedge CLK)
	begin
		if (alloc_en)
		begin
			tag_q[alloc_set][alloc_way] <= alloc_tag;
			target_q[alloc_set][alloc_way] <= alloc_target;
			ctr_q[alloc_set][alloc_way] <= alloc_ctr;
		end
		if (upd_en && !upd_blocked)
		begin
			ctr_q[upd_set][upd_way] <= upd_ctr;
		end
	end

endmodule

//--- rtl/bht_way_match.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module bht_way_match
(
	input logic [`BP_TAG_W-1:0] tag,
	input bp_pkg::bht_entry_t set_entries [`BP_WAYS],
	output logic hit,
	output logic [`BP_WAY_W-1:0] hit_way,
	output bp_pkg::bht_entry_t hit_entry
);

	// per-way match vector
	logic [`BP_WAYS-1:0] way_eq;

	always_comb
	begin
		for (int w = 0; w < `BP_WAYS; w++)
		begin
			// an invalid way never matches, whatever its stale tag holds
			way_eq[w] = set_entries[w].valid && (set_entries[w].tag == tag);
		end
	end

	// tags are unique within a set so at most one bit of way_eq is set
	always_comb
	begin
		hit = 1'b0;
		hit_way = '0;
		hit_entry = '0;
		for (int w = 0; w < `BP_WAYS; w++)
		begin
			if (way_eq[w])
			begin
				hit = 1'b1;
				hit_way = w[`BP_WAY_W-1:0];
				hit_entry = set_entries[w];
			end
		end
	end

	// on a miss the entry stays all zero
	// so counter bit 1 and target read back as 0

endmodule

//--- rtl/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// instruction address width
`define BP_PC_W 10

// low address bits select the set
`define BP_SET_W 4

// remaining upper address bits form the tag
`define BP_TAG_W 6

// associativity of the history table
`define BP_WAYS 4
`define BP_WAY_W 2

// saturating counter width
`define BP_CTR_W 2

`endif

//--- rtl/bp_pkg.sv
`include "bp_defines.svh"

package bp_pkg;

	//////////////////////////////////////////////////
	// history table entry
	//////////////////////////////////////////////////

	// msb first: valid, tag, branch target, counter
	typedef struct packed
	{
		logic valid;
		logic [`BP_TAG_W-1:0] tag;
		logic [`BP_PC_W-1:0] target;
		logic [`BP_CTR_W-1:0] ctr;
	} bht_entry_t;

	// initial counter values on allocation
	localparam logic [`BP_CTR_W-1:0] CTR_WEAK_NT = 2'b01;
	localparam logic [`BP_CTR_W-1:0] CTR_STRONG_T = 2'b11;

	// execute stage redirect code
	// upper bit set means fetch must be redirected
	typedef enum logic [1:0]
	{
		CORR_NONE = 2'b00,
		CORR_CNI = 2'b10,
		CORR_PBT = 2'b11
	} corr_e;

	// one-hot branch type, bit 5 down to 0 is beq bne blt bge bltu bgeu
	typedef logic [5:0] btype_t;

endpackage

//--- rtl/branch_predictor.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module branch_predictor
(
	input logic CLK,
	input logic reset,
	input logic stall,

	// decode stage
	input logic [`BP_PC_W-1:0] id_pc,
	input logic [`BP_PC_W-1:0] id_target,
	input logic id_is_btype,
	input logic id_is_jump,

	// execute stage
	input logic [`BP_PC_W-1:0] exe_pc,
	input bp_pkg::btype_t exe_btype,
	input logic exe_z,
	input logic exe_less,
	input logic [`BP_PC_W-1:0] exe_target,

	// fetch stage
	output logic [`BP_PC_W-1:0] fetch_pc,
	output logic if_prediction,
	output logic [`BP_PC_W-1:0] if_pbt,

	// redirect
	output bp_pkg::corr_e exe_correction,
	output logic [`BP_PC_W-1:0] exe_cni,
	output logic flush
);

	localparam logic [`BP_PC_W-1:0] PC_STEP = 4;

	// set contents seen by each stage
	bp_pkg::bht_entry_t if_set [`BP_WAYS];
	bp_pkg::bht_entry_t id_set [`BP_WAYS];
	bp_pkg::bht_entry_t exe_set [`BP_WAYS];

	logic if_hit;
	bp_pkg::bht_entry_t if_entry;
	logic id_hit;
	logic exe_hit;
	logic [`BP_WAY_W-1:0] exe_way;
	bp_pkg::bht_entry_t exe_entry;

	// resolver to table
	logic upd_en;
	logic [`BP_CTR_W-1:0] upd_ctr;
	// allocate only for a branch or jump that misses
	logic alloc_en;

	assign alloc_en = (id_is_btype || id_is_jump) && !id_hit;

	//////////////////////////////////////////////////
	// shared table
	//////////////////////////////////////////////////

	// address splits into {tag, set}
	bht_table i_bht_table
	(
		.CLK (CLK),
		.reset (reset),
		.rd_set_a (fetch_pc[`BP_SET_W-1:0]),
		.rd_set_b (id_pc[`BP_SET_W-1:0]),
		.rd_set_c (exe_pc[`BP_SET_W-1:0]),
		.set_a (if_set),
		.set_b (id_set),
		.set_c (exe_set),
		.alloc_en (alloc_en),
		.alloc_set (id_pc[`BP_SET_W-1:0]),
		.alloc_tag (id_pc[`BP_PC_W-1:`BP_SET_W]),
		.alloc_target (id_target),
		.alloc_is_jump (id_is_jump),
		.upd_en (upd_en),
		.upd_set (exe_pc[`BP_SET_W-1:0]),
		.upd_way (exe_way),
		.upd_ctr (upd_ctr)
	);

	//////////////////////////////////////////////////
	// stage lookups
	//////////////////////////////////////////////////

	// fetch only needs the entry
	bht_way_match i_match_if
	(
		.tag (fetch_pc[`BP_PC_W-1:`BP_SET_W]),
		.set_entries (if_set),
		.hit (if_hit),
		.hit_way (),
		.hit_entry (if_entry)
	);

	// decode only needs to know whether the branch is already present
	bht_way_match i_match_id
	(
		.tag (id_pc[`BP_PC_W-1:`BP_SET_W]),
		.set_entries (id_set),
		.hit (id_hit),
		.hit_way (),
		.hit_entry ()
	);

	// execute needs the way for the counter write-back
	bht_way_match i_match_exe
	(
		.tag (exe_pc[`BP_PC_W-1:`BP_SET_W]),
		.set_entries (exe_set),
		.hit (exe_hit),
		.hit_way (exe_way),
		.hit_entry (exe_entry)
	);

	// taken when the counter upper bit is set
	assign if_prediction = if_hit && if_entry.ctr[1];
	assign if_pbt = if_entry.target;

	//////////////////////////////////////////////////
	// resolution and next fetch address
	//////////////////////////////////////////////////

	branch_resolve i_branch_resolve
	(
		.exe_btype (exe_btype),
		.exe_z (exe_z),
		.exe_less (exe_less),
		.exe_hit (exe_hit),
		.exe_entry (exe_entry),
		.exe_correction (exe_correction),
		.upd_en (upd_en),
		.upd_ctr (upd_ctr)
	);

	// instruction after the branch
	assign exe_cni = exe_pc + PC_STEP;
	assign flush = (exe_correction != bp_pkg::CORR_NONE);

	fetch_pc_gen i_fetch_pc_gen
	(
		.CLK (CLK),
		.reset (reset),
		.stall (stall),
		.exe_correction (exe_correction),
		.exe_target (exe_target),
		.exe_cni (exe_cni),
		.if_prediction (if_prediction),
		.if_pbt (if_pbt),
		.fetch_pc (fetch_pc)
	);

endmodule

//--- rtl/branch_resolve.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module branch_resolve
(
	input bp_pkg::btype_t exe_btype,
	input logic exe_z,
	input logic exe_less,
	input logic exe_hit,
	input bp_pkg::bht_entry_t exe_entry,
	output bp_pkg::corr_e exe_correction,
	output logic upd_en,
	output logic [`BP_CTR_W-1:0] upd_ctr
);

	localparam logic [`BP_CTR_W-1:0] CTR_MAX = {`BP_CTR_W{1'b1}};
	localparam logic [`BP_CTR_W-1:0] CTR_MIN = '0;

	// any conditional branch in execute
	logic is_branch;
	// condition result per branch type, same bit order as btype
	logic [5:0] cond;
	// actual branch direction
	logic outcome;
	// direction fetch assumed
	logic predicted;

	assign is_branch = |exe_btype;

	// beq bne blt bge bltu bgeu
	// unsigned compares share the less flag with the signed ones
	assign cond = {exe_z, !exe_z, exe_less, !exe_less, exe_less, !exe_less};
	assign outcome = |(exe_btype & cond);

	// a table miss was fetched as not taken
	assign predicted = exe_hit && exe_entry.ctr[1];

	// only resolved branches can redirect
	always_comb
	begin
		if (!is_branch || (predicted == outcome))
			exe_correction = bp_pkg::CORR_NONE;
		else if (outcome)
			exe_correction = bp_pkg::CORR_PBT;
		else
			exe_correction = bp_pkg::CORR_CNI;
	end

	// counter write-back only for a branch that owns an entry
	assign upd_en = is_branch && exe_hit;

	// one step toward the outcome, saturating at both ends
	always_comb
	begin
		if (outcome)
			upd_ctr = (exe_entry.ctr == CTR_MAX) ? CTR_MAX : exe_entry.ctr + 1'b1;
		else
			upd_ctr = (exe_entry.ctr == CTR_MIN) ? CTR_MIN : exe_entry.ctr - 1'b1;
	end

endmodule

//--- rtl/fetch_pc_gen.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module fetch_pc_gen
(
	input logic CLK,
	input logic reset,
	input logic stall,
	input bp_pkg::corr_e exe_correction,
	input logic [`BP_PC_W-1:0] exe_target,
	input logic [`BP_PC_W-1:0] exe_cni,
	input logic if_prediction,
	input logic [`BP_PC_W-1:0] if_pbt,
	output logic [`BP_PC_W-1:0] fetch_pc
);

	// sequential fetch step
	localparam logic [`BP_PC_W-1:0] PC_STEP = 4;

	logic [`BP_PC_W-1:0] next_pc;

	// execute redirects beat stall, stall beats the fetch prediction
	always_comb
	begin
		case (exe_correction)
			bp_pkg::CORR_PBT: next_pc = exe_target;
			bp_pkg::CORR_CNI: next_pc = exe_cni;
			default:
			begin
				if (stall)
					next_pc = fetch_pc;
				else if (if_prediction)
					next_pc = if_pbt;
				else
					next_pc = fetch_pc + PC_STEP;
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			fetch_pc <= '0;
		else
			fetch_pc <= next_pc;
	end

endmodule

//--- tests/tb_branch_predictor.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module tb_branch_predictor;

	localparam int NUM_SETS = 1 << `BP_SET_W;
	// never allocated so a taken branch here always misses and redirects
	localparam logic [`BP_PC_W-1:0] STEER_PC = 10'h3fc;
	localparam bp_pkg::btype_t BEQ = 6'b100000;
	localparam bp_pkg::btype_t BNE = 6'b010000;

	logic CLK;
	logic reset;
	logic stall;
	logic [`BP_PC_W-1:0] id_pc;
	logic [`BP_PC_W-1:0] id_target;
	logic id_is_btype;
	logic id_is_jump;
	logic [`BP_PC_W-1:0] exe_pc;
	bp_pkg::btype_t exe_btype;
	logic exe_z;
	logic exe_less;
	logic [`BP_PC_W-1:0] exe_target;
	logic [`BP_PC_W-1:0] fetch_pc;
	logic if_prediction;
	logic [`BP_PC_W-1:0] if_pbt;
	bp_pkg::corr_e exe_correction;
	logic [`BP_PC_W-1:0] exe_cni;
	logic flush;

	//////////////////////////////////////////////////
	// reference model state
	//////////////////////////////////////////////////

	logic m_valid [NUM_SETS][`BP_WAYS];
	logic [`BP_TAG_W-1:0] m_tag [NUM_SETS][`BP_WAYS];
	logic [`BP_PC_W-1:0] m_target [NUM_SETS][`BP_WAYS];
	logic [`BP_CTR_W-1:0] m_ctr [NUM_SETS][`BP_WAYS];
	logic [`BP_WAY_W-1:0] m_ptr [NUM_SETS];

	// expected outputs settled on the falling edge
	logic [`BP_PC_W-1:0] exp_pc;
	logic exp_pred;
	logic [`BP_PC_W-1:0] exp_pbt;
	bp_pkg::corr_e exp_corr;
	logic [`BP_PC_W-1:0] exp_cni;
	logic exp_flush;

	int errors;
	int tests_run;
	int tests_failed;
	logic [`BP_PC_W-1:0] fifo_pc [6];

	branch_predictor i_branch_predictor
	(
		.CLK (CLK),
		.reset (reset),
		.stall (stall),
		.id_pc (id_pc),
		.id_target (id_target),
		.id_is_btype (id_is_btype),
		.id_is_jump (id_is_jump),
		.exe_pc (exe_pc),
		.exe_btype (exe_btype),
		.exe_z (exe_z),
		.exe_less (exe_less),
		.exe_target (exe_target),
		.fetch_pc (fetch_pc),
		.if_prediction (if_prediction),
		.if_pbt (if_pbt),
		.exe_correction (exe_correction),
		.exe_cni (exe_cni),
		.flush (flush)
	);

	initial
		CLK = 1'b0;
	always #50 CLK = ~CLK;

	//////////////////////////////////////////////////
	// output checks
	//////////////////////////////////////////////////

	fetch_pc_check: assert property (@(posedge CLK) disable iff (reset) fetch_pc == exp_pc)
	else
	begin
		errors++;
		$display("mismatch at %0t: fetch_pc expected %h got %h", $time,
			$sampled(exp_pc), $sampled(fetch_pc));
	end

	pred_check: assert property (@(posedge CLK) disable iff (reset) if_prediction == exp_pred)
	else
	begin
		errors++;
		$display("mismatch at %0t: if_prediction expected %b got %b", $time,
			$sampled(exp_pred), $sampled(if_prediction));
	end

	pbt_check: assert property (@(posedge CLK) disable iff (reset) if_pbt == exp_pbt)
	else
	begin
		errors++;
		$display("mismatch at %0t: if_pbt expected %h got %h", $time,
			$sampled(exp_pbt), $sampled(if_pbt));
	end

	corr_check: assert property (@(posedge CLK) disable iff (reset) exe_correction == exp_corr)
	else
	begin
		errors++;
		$display("mismatch at %0t: exe_correction expected %b got %b", $time,
			$sampled(exp_corr), $sampled(exe_correction));
	end

	cni_check: assert property (@(posedge CLK) disable iff (reset) exe_cni == exp_cni)
	else
	begin
		errors++;
		$display("mismatch at %0t: exe_cni expected %h got %h", $time,
			$sampled(exp_cni), $sampled(exe_cni));
	end

	flush_check: assert property (@(posedge CLK) disable iff (reset) flush == exp_flush)
	else
	begin
		errors++;
		$display("mismatch at %0t: flush expected %b got %b", $time,
			$sampled(exp_flush), $sampled(flush));
	end

	//////////////////////////////////////////////////
	// model
	//////////////////////////////////////////////////

	// search the model set of pc for its tag
	function automatic logic lookup(input logic [`BP_PC_W-1:0] pc, output int way);
		logic found;
		logic [`BP_SET_W-1:0] s;
		found = 1'b0;
		way = 0;
		s = pc[`BP_SET_W-1:0];
		for (int w = 0; w < `BP_WAYS; w++)
		begin
			if (m_valid[s][w] && m_tag[s][w] == pc[`BP_PC_W-1:`BP_SET_W])
			begin
				found = 1'b1;
				way = w;
			end
		end
		return found;
	endfunction

	// beq bne blt bge bltu bgeu from the zero and less flags
	function automatic logic branch_taken(input bp_pkg::btype_t bt, input logic z,
			input logic less);
		return (bt[5] && z) || (bt[4] && !z) || (bt[3] && less) || (bt[2] && !less)
			|| (bt[1] && less) || (bt[0] && !less);
	endfunction

	// combinational outputs for the inputs now applied
	task automatic predict_outputs();
		int w;
		logic hit;
		logic taken;
		logic guess;
		logic [`BP_SET_W-1:0] s;
		hit = lookup(exp_pc, w);
		s = exp_pc[`BP_SET_W-1:0];
		exp_pred = hit && m_ctr[s][w][1];
		exp_pbt = hit ? m_target[s][w] : '0;
		hit = lookup(exe_pc, w);
		s = exe_pc[`BP_SET_W-1:0];
		// a miss was fetched as not taken
		guess = hit && m_ctr[s][w][1];
		taken = branch_taken(exe_btype, exe_z, exe_less);
		exp_cni = exe_pc + 10'd4;
		if (exe_btype == '0 || guess == taken)
			exp_corr = bp_pkg::CORR_NONE;
		else if (taken)
			exp_corr = bp_pkg::CORR_PBT;
		else
			exp_corr = bp_pkg::CORR_CNI;
		exp_flush = exp_corr != bp_pkg::CORR_NONE;
	endtask

	// state change of the rising edge just passed
	task automatic commit_model();
		int ew;
		int iw;
		logic ehit;
		logic ihit;
		logic taken;
		logic [`BP_SET_W-1:0] es;
		logic [`BP_SET_W-1:0] ds;
		logic [`BP_CTR_W-1:0] ctr;
		ehit = lookup(exe_pc, ew);
		ihit = lookup(id_pc, iw);
		taken = branch_taken(exe_btype, exe_z, exe_less);
		es = exe_pc[`BP_SET_W-1:0];
		ds = id_pc[`BP_SET_W-1:0];
		// redirects first, then stall, then prediction
		if (exp_corr == bp_pkg::CORR_PBT)
			exp_pc = exe_target;
		else if (exp_corr == bp_pkg::CORR_CNI)
			exp_pc = exp_cni;
		else if (!stall)
			exp_pc = exp_pred ? exp_pbt : exp_pc + 10'd4;
		if (exe_btype != '0 && ehit)
		begin
			ctr = m_ctr[es][ew];
			if (taken && ctr != 2'b11)
				ctr = ctr + 2'd1;
			else if (!taken && ctr != 2'b00)
				ctr = ctr - 2'd1;
			m_ctr[es][ew] = ctr;
		end
		// allocation last so it overrides an update of the same entry
		if ((id_is_btype || id_is_jump) && !ihit)
		begin
			m_valid[ds][m_ptr[ds]] = 1'b1;
			m_tag[ds][m_ptr[ds]] = id_pc[`BP_PC_W-1:`BP_SET_W];
			m_target[ds][m_ptr[ds]] = id_target;
			m_ctr[ds][m_ptr[ds]] = id_is_jump ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_WEAK_NT;
			m_ptr[ds] = m_ptr[ds] + 2'd1;
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// stall stays as the tests set it
	task automatic clear_inputs();
		id_pc = '0;
		id_target = '0;
		id_is_btype = 1'b0;
		id_is_jump = 1'b0;
		exe_pc = '0;
		exe_btype = '0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_target = '0;
	endtask

	// one clock entered and left on a falling edge
	task automatic cycle();
		predict_outputs();
		@(posedge CLK);
		@(negedge CLK);
		commit_model();
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			clear_inputs();
			cycle();
		end
	endtask

	task automatic allocate(input logic [`BP_PC_W-1:0] pc, input logic [`BP_PC_W-1:0] target,
			input logic is_jump);
		clear_inputs();
		id_pc = pc;
		id_target = target;
		id_is_btype = !is_jump;
		id_is_jump = is_jump;
		cycle();
	endtask

	task automatic resolve(input logic [`BP_PC_W-1:0] pc, input bp_pkg::btype_t bt,
			input logic z, input logic less, input logic [`BP_PC_W-1:0] target);
		clear_inputs();
		exe_pc = pc;
		exe_btype = bt;
		exe_z = z;
		exe_less = less;
		exe_target = target;
		cycle();
	endtask

	// a taken miss sends fetch to addr
	task automatic steer(input logic [`BP_PC_W-1:0] addr);
		resolve(STEER_PC, BEQ, 1'b1, 1'b0, addr);
	endtask

	task automatic wait_fetch(input logic [`BP_PC_W-1:0] pc, input int limit);
		int n;
		n = 0;
		while (fetch_pc != pc && n < limit)
		begin
			idle(1);
			n++;
		end
		if (fetch_pc != pc)
		begin
			errors++;
			$display("timeout: fetch address never reached %h after %0d cycles", pc, limit);
		end
	endtask

	// random tag in 1..62 keeps clear of the steering address
	function automatic logic [`BP_PC_W-1:0] branch_addr(input logic [`BP_SET_W-1:0] set);
		logic [31:0] r;
		r = $urandom_range(62, 1);
		return {r[`BP_TAG_W-1:0], set};
	endfunction

	function automatic logic [`BP_PC_W-1:0] rand_target();
		logic [31:0] r;
		r = $urandom;
		return {r[`BP_PC_W-1:2], 2'b00};
	endfunction

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, errors - errors_before);
		end
	endtask

	initial
	begin
		int mark;
		logic [`BP_PC_W-1:0] jmp_pc;
		logic [`BP_PC_W-1:0] jmp_tgt;
		logic [`BP_PC_W-1:0] br_pc;
		logic [`BP_PC_W-1:0] br_tgt;
		logic [31:0] base;
		void'($urandom(32'h2674));
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reset = 1'b1;
		stall = 1'b0;
		clear_inputs();
		for (int s = 0; s < NUM_SETS; s++)
		begin
			m_ptr[s] = '0;
			for (int w = 0; w < `BP_WAYS; w++)
				m_valid[s][w] = 1'b0;
		end
		exp_pc = '0;
		predict_outputs();
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;

		mark = errors;
		idle(6);
		stall = 1'b1;
		idle(4);
		stall = 1'b0;
		idle(2);
		end_test("reset and sequential fetch", mark);

		// jump sits in set 0 and the taken miss brings fetch onto it
		mark = errors;
		jmp_pc = branch_addr(4'h0);
		jmp_tgt = rand_target();
		allocate(jmp_pc, jmp_tgt, 1'b1);
		steer(jmp_pc);
		wait_fetch(jmp_tgt, 4);
		idle(2);
		end_test("miss redirect and jump allocation", mark);

		mark = errors;
		br_pc = branch_addr(4'h4);
		br_tgt = rand_target();
		allocate(br_pc, br_tgt, 1'b0);
		steer(br_pc);
		idle(1);
		// 01 to 10 to 11
		resolve(br_pc, BEQ, 1'b1, 1'b0, br_tgt);
		resolve(br_pc, BEQ, 1'b1, 1'b0, br_tgt);
		steer(br_pc);
		wait_fetch(br_tgt, 4);
		resolve(br_pc, BEQ, 1'b1, 1'b0, br_tgt);
		resolve(br_pc, BEQ, 1'b1, 1'b0, br_tgt);
		end_test("counter training", mark);

		mark = errors;
		resolve(br_pc, BEQ, 1'b0, 1'b0, br_tgt);
		wait_fetch(br_pc + 10'd4, 2);
		for (int b = 0; b < 6; b++)
		begin
			for (int f = 0; f < 4; f++)
				resolve(br_pc, 6'b000001 << b, f[1], f[0], br_tgt);
		end
		end_test("misprediction correction", mark);

		// jumps start at 11 so a not-taken resolve shows a hit as a correction
		mark = errors;
		base = $urandom_range(50, 1);
		for (int i = 0; i < 6; i++)
			fifo_pc[i] = {base[`BP_TAG_W-1:0] + 6'(i), 4'h8};
		for (int i = 0; i < 5; i++)
			allocate(fifo_pc[i], rand_target(), 1'b1);
		for (int i = 0; i < 5; i++)
			resolve(fifo_pc[i], BNE, 1'b1, 1'b0, rand_target());
		// already present so the pointer must not move
		allocate(fifo_pc[1], rand_target(), 1'b1);
		allocate(fifo_pc[5], rand_target(), 1'b1);
		for (int i = 1; i < 6; i++)
			resolve(fifo_pc[i], BNE, 1'b1, 1'b0, rand_target());
		end_test("fifo replacement", mark);

		mark = errors;
		br_tgt = rand_target();
		stall = 1'b1;
		steer(br_tgt);
		wait_fetch(br_tgt, 2);
		idle(2);
		jmp_pc = branch_addr(4'h0);
		allocate(jmp_pc, rand_target(), 1'b1);
		resolve(jmp_pc, BNE, 1'b1, 1'b0, rand_target());
		wait_fetch(jmp_pc + 10'd4, 2);
		idle(2);
		stall = 1'b0;
		idle(2);
		end_test("redirect over stall", mark);

		$display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+rtl
rtl/bp_pkg.sv
rtl/bht_way_match.sv
rtl/bht_table.sv
rtl/branch_resolve.sv
rtl/fetch_pc_gen.sv
rtl/branch_predictor.sv
tests/tb_branch_predictor.sv
